//--- wallace_multiplier.f
verilog/mul_pkg.sv
verilog/booth_encoder.sv
verilog/wallace_tree.sv
verilog/wallace_multiplier.sv
testbench/wallace_multiplier_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps -j 0 \
  --top-module wallace_multiplier_tb \
  -f wallace_multiplier.f \
  -o wallace_multiplier_sim

./obj_dir/wallace_multiplier_sim

//--- testbench/wallace_multiplier_tb.sv
// fixed seed and 2000 accepted requests; the first mismatch or timeout ends the run with $fatal
`timescale 1ns/1ps

module wallace_multiplier_tb;

  import mul_pkg::*;

  localparam int NUM_REQ     = 2000;
  localparam int MAX_CYCLES  = 20000;
  localparam int DRAIN_LIMIT = 50;
  localparam int NUM_CORNER  = 6;
  // operands widened past the product width so every mode multiplies exactly
  localparam int MODEL_W     = 2 * DATA_WIDTH + 2;

  localparam logic [DATA_WIDTH-1:0] ALL_ONES = '1;
  localparam logic [DATA_WIDTH-1:0] MOST_NEG = {1'b1, {(DATA_WIDTH - 1){1'b0}}};

  logic     clock = 1'b0;
  logic     reset;
  logic     flush_i;
  logic     mul_valid_i;
  mul_req_t mul_req_i;
  logic     mul_ready_o;
  logic     res_valid_o;
  logic     res_ready_i;
  mul_res_t res_o;

  integer   seed = 32'hd3122fde;
  int       accepted = 0;
  int       cycles = 0;
  int       waited = 0;
  int       corner_seen = 0;
  // expected products in acceptance order
  mul_res_t exp_q[$];

  // what the consumer saw at the previous falling edge
  logic     flush_seen = 1'b0;
  logic     hold_seen = 1'b0;

  wallace_multiplier dut (
    .clock       (clock),
    .reset       (reset),
    .flush_i     (flush_i),
    .mul_valid_i (mul_valid_i),
    .mul_req_i   (mul_req_i),
    .mul_ready_o (mul_ready_o),
    .res_valid_o (res_valid_o),
    .res_ready_i (res_ready_i),
    .res_o       (res_o)
  );

  always #10 clock = ~clock;

  task automatic abort_run(string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_result(mul_res_t got, mul_res_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Fail res_o.hi got %h exp %h, res_o.lo got %h exp %h",
                          got.hi, exp.hi, got.lo, exp.lo));
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      abort_run($sformatf("Fail %s got %h exp %h", name, got, exp));
    end
  endtask

  // full product of the two extended operands truncated to 64 bits
  function automatic mul_res_t model_product(mul_req_t req);
    logic [MODEL_W-1:0] a_w;
    logic [MODEL_W-1:0] b_w;
    logic [MODEL_W-1:0] p_w;
    mul_res_t           res;
    a_w = {{(MODEL_W - DATA_WIDTH){req.mode.a_signed & req.multiplicand[DATA_WIDTH-1]}},
           req.multiplicand};
    b_w = {{(MODEL_W - DATA_WIDTH){req.mode.b_signed & req.multiplier[DATA_WIDTH-1]}},
           req.multiplier};
    p_w = a_w * b_w;
    res.hi = p_w[2*DATA_WIDTH-1:DATA_WIDTH];
    res.lo = p_w[DATA_WIDTH-1:0];
    return res;
  endfunction

  // corner value about one time in four
  function automatic logic [DATA_WIDTH-1:0] pick_operand();
    logic [31:0]           r;
    logic [DATA_WIDTH-1:0] val;
    r = $random(seed);
    if (r[1:0] == 2'b00) begin
      case (r[3:2])
        2'd0:    val = '0;
        2'd1:    val = ALL_ONES;
        2'd2:    val = MOST_NEG;
        default: val = DATA_WIDTH'(1);
      endcase
    end else begin
      val = $random(seed);
    end
    return val;
  endfunction

  task automatic drive_req(mul_mode_t mode, logic [DATA_WIDTH-1:0] a,
                           logic [DATA_WIDTH-1:0] b);
    mul_req_t req;
    req.mode         = mode;
    req.multiplicand = a;
    req.multiplier   = b;
    mul_valid_i <= 1'b1;
    mul_req_i   <= req;
  endtask

  task automatic drive_random();
    logic [31:0] r;
    mul_req_t    req;
    r = $random(seed);
    req.mode         = mul_mode_t'(r[1:0]);
    req.multiplicand = pick_operand();
    req.multiplier   = pick_operand();
    mul_valid_i <= (r[3:2] != 2'b00);
    res_ready_i <= (r[5:4] != 2'b00);
    // flush roughly once in forty cycles
    flush_i     <= (($unsigned($random(seed)) % 32'd40) == 32'd0);
    mul_req_i   <= req;
  endtask

  // samples one cycle of the corner burst and fails on an idle cycle inside it
  task automatic count_corner_result();
    @(negedge clock);
    if (res_valid_o) begin
      corner_seen++;
    end else if (corner_seen != 0 && corner_seen < NUM_CORNER) begin
      abort_run("back-to-back results came out with an idle cycle between them");
    end
  endtask

  // inputs are stable here, so each check sees what the next rising edge will sample
  always @(negedge clock) begin : model_check
    mul_res_t exp_res;
    if (!reset) begin
      check_flag("mul_ready_o", mul_ready_o, !(res_valid_o && !res_ready_i));
      if (res_valid_o && exp_q.size() == 0) begin
        abort_run("a result appeared with no accepted request outstanding");
      end
      if (flush_seen) begin
        check_flag("res_valid_o", res_valid_o, 1'b0);
      end else if (hold_seen) begin
        // a held result is still the oldest outstanding product
        check_flag("res_valid_o", res_valid_o, 1'b1);
        check_result(res_o, exp_q[0]);
      end
      if (res_valid_o && res_ready_i) begin
        exp_res = exp_q.pop_front();
        check_result(res_o, exp_res);
      end
      // a flush drops everything in flight including a held result
      if (flush_i) begin
        exp_q.delete();
      end
      if (mul_valid_i && mul_ready_o && !flush_i) begin
        exp_q.push_back(model_product(mul_req_i));
        accepted++;
      end
      flush_seen = flush_i;
      hold_seen  = res_valid_o && !res_ready_i;
    end
  end

  initial begin : stimulus
    reset       <= 1'b1;
    flush_i     <= 1'b0;
    mul_valid_i <= 1'b0;
    mul_req_i   <= '0;
    res_ready_i <= 1'b0;
    repeat (2) @(posedge clock);
    reset <= 1'b0;

    // idle state straight out of reset
    @(negedge clock);
    check_flag("res_valid_o", res_valid_o, 1'b0);
    check_flag("mul_ready_o", mul_ready_o, 1'b1);

    // sign corners back to back with the consumer always ready
    @(posedge clock);
    res_ready_i <= 1'b1;
    drive_req(mul_mode_t'(2'b11), MOST_NEG, MOST_NEG);
    count_corner_result();
    @(posedge clock);
    drive_req(mul_mode_t'(2'b11), MOST_NEG, ALL_ONES);
    count_corner_result();
    @(posedge clock);
    drive_req(mul_mode_t'(2'b10), MOST_NEG, ALL_ONES);
    count_corner_result();
    @(posedge clock);
    drive_req(mul_mode_t'(2'b01), ALL_ONES, MOST_NEG);
    count_corner_result();
    @(posedge clock);
    drive_req(mul_mode_t'(2'b00), ALL_ONES, ALL_ONES);
    count_corner_result();
    @(posedge clock);
    drive_req(mul_mode_t'(2'b00), MOST_NEG, MOST_NEG);
    count_corner_result();

    // the burst leaves one result per cycle
    @(posedge clock);
    mul_valid_i <= 1'b0;
    while (corner_seen < NUM_CORNER) begin
      if (waited == DRAIN_LIMIT) begin
        abort_run("the corner results stopped arriving");
      end
      waited++;
      count_corner_result();
    end
    waited = 0;

    while (accepted < NUM_REQ) begin
      @(posedge clock);
      if (cycles == MAX_CYCLES) begin
        abort_run("requests stopped being accepted before the target count");
      end
      cycles++;
      drive_random();
    end

    // drain with the consumer ready
    mul_valid_i <= 1'b0;
    flush_i     <= 1'b0;
    res_ready_i <= 1'b1;
    while (exp_q.size() != 0) begin
      @(posedge clock);
      if (waited == DRAIN_LIMIT) begin
        abort_run("results stopped arriving while requests were still outstanding");
      end
      waited++;
    end
    @(negedge clock);
    check_flag("res_valid_o", res_valid_o, 1'b0);
    $display("Regression passed");
    $finish;
  end

endmodule

//--- verilog/wallace_multiplier.sv
// 3-stage pipe, one request per cycle; a held result stalls every stage and flush drops all work
`timescale 1ns/1ps

module wallace_multiplier (
  input  logic              clock,
  input  logic              reset,
  input  logic              flush_i,
  input  logic              mul_valid_i,
  input  mul_pkg::mul_req_t mul_req_i,
  output logic              mul_ready_o,
  output logic              res_valid_o,
  input  logic              res_ready_i,
  output mul_pkg::mul_res_t res_o
);

  import mul_pkg::*;

  // stage 1, operands
  logic      op_valid_q;
  mul_req_t  op_q;

  // stage 2, carry-save pair
  logic      cs_valid_q;
  pp_row_t   sum_q;
  pp_row_t   carry_q;

  // stage 3, product
  logic      res_valid_q;
  mul_res_t  res_q;

  logic      stall;
  logic      accept;

  pp_array_t         pp;
  pp_row_t           tree_sum;
  pp_row_t           tree_carry;
  logic [PP_LEN-1:0] prod_full;
  mul_res_t          prod;

  // result held by the consumer freezes the whole pipe
  assign stall       = res_valid_q & ~res_ready_i;
  assign mul_ready_o = ~stall;
  assign accept      = mul_valid_i & mul_ready_o & ~flush_i;

  booth_encoder u_booth (
    .req_i (op_q),
    .pp_o  (pp)
  );

  wallace_tree u_tree (
    .pp_i    (pp),
    .sum_o   (tree_sum),
    .carry_o (tree_carry)
  );

  // carry row comes pre-shifted from the tree
  assign prod_full = sum_q + carry_q;
  assign prod      = prod_full[2*DATA_WIDTH-1:0];

  // valid flags
  always_ff @(posedge clock) begin
    if (reset) begin
      op_valid_q  <= 1'b0;
      cs_valid_q  <= 1'b0;
      res_valid_q <= 1'b0;
    end else if (flush_i) begin
      op_valid_q  <= 1'b0;
      cs_valid_q  <= 1'b0;
      res_valid_q <= 1'b0;
    end else if (!stall) begin
      op_valid_q  <= accept;
      cs_valid_q  <= op_valid_q;
      res_valid_q <= cs_valid_q;
    end
  end

  // payload moves only when the pipe advances
  always_ff @(posedge clock) begin
    if (!stall) begin
      if (accept) begin
        op_q <= mul_req_i;
      end
      sum_q   <= tree_sum;
      carry_q <= tree_carry;
      res_q   <= prod;
    end
  end

  assign res_valid_o = res_valid_q;
  assign res_o       = res_q;

  // held result keeps its value across the stall
  a_res_stable : assert property (
    @(posedge clock) disable iff (reset)
    (res_valid_o && !res_ready_i) |=> $stable(res_o)
  );

  // flush empties every stage
  a_flush_clears : assert property (
    @(posedge clock) disable iff (reset)
    flush_i |=> !(op_valid_q || cs_valid_q || res_valid_q)
  );

  // only a held result may block new requests
  a_ready_when_idle : assert property (
    @(posedge clock) disable iff (reset)
    !res_valid_o |-> mul_ready_o
  );

endmodule

//--- verilog/wallace_tree.sv
// combinational 17-to-2 reduction; carry_o is already shifted so the caller just adds both rows
`timescale 1ns/1ps

module wallace_tree (
  input  mul_pkg::pp_array_t pp_i,
  output mul_pkg::pp_row_t   sum_o,
  output mul_pkg::pp_row_t   carry_o
);

  import mul_pkg::*;

  localparam int L1_CSA = 5;
  localparam int L2_CSA = 4;
  localparam int L3_CSA = 2;
  localparam int L4_CSA = 2;

  // bitwise full adder, sum half
  function automatic pp_row_t csa_sum(pp_row_t x, pp_row_t y, pp_row_t z);
    return x ^ y ^ z;
  endfunction

  // bitwise full adder, carry half moved up one weight
  function automatic pp_row_t csa_carry(pp_row_t x, pp_row_t y, pp_row_t z);
    return ((x & y) | (x & z) | (y & z)) << 1;
  endfunction

  pp_row_t l1_s  [L1_CSA];
  pp_row_t l1_c  [L1_CSA];
  pp_row_t l2_in [3*L2_CSA];
  pp_row_t l2_s  [L2_CSA];
  pp_row_t l2_c  [L2_CSA];
  pp_row_t l3_in [3*L3_CSA];
  pp_row_t l3_s  [L3_CSA];
  pp_row_t l3_c  [L3_CSA];
  pp_row_t l4_in [3*L4_CSA];
  pp_row_t l4_s  [L4_CSA];
  pp_row_t l4_c  [L4_CSA];
  pp_row_t l5_s;
  pp_row_t l5_c;

  genvar k;

  // level 1: rows 2..16 in triples, rows 0 and 1 skip ahead (17 -> 12)
  for (k = 0; k < L1_CSA; k++) begin : g_l1
    assign l1_s[k] = csa_sum(pp_i[3*k+2], pp_i[3*k+3], pp_i[3*k+4]);
    assign l1_c[k] = csa_carry(pp_i[3*k+2], pp_i[3*k+3], pp_i[3*k+4]);
  end

  // level 2 input order: carries, the two skipped rows, then sums
  for (k = 0; k < L1_CSA; k++) begin : g_l2_in
    assign l2_in[k]     = l1_c[k];
    assign l2_in[k + 7] = l1_s[k];
  end
  assign l2_in[5] = pp_i[0];
  assign l2_in[6] = pp_i[1];

  // level 2: 12 -> 8
  for (k = 0; k < L2_CSA; k++) begin : g_l2
    assign l2_s[k] = csa_sum(l2_in[3*k], l2_in[3*k+1], l2_in[3*k+2]);
    assign l2_c[k] = csa_carry(l2_in[3*k], l2_in[3*k+1], l2_in[3*k+2]);
  end

  // level 3: two carries and all sums of level 2, carries 2 and 3 wait (8 -> 6)
  assign l3_in[0] = l2_c[0];
  assign l3_in[1] = l2_c[1];
  for (k = 0; k < L2_CSA; k++) begin : g_l3_in
    assign l3_in[k + 2] = l2_s[k];
  end

  for (k = 0; k < L3_CSA; k++) begin : g_l3
    assign l3_s[k] = csa_sum(l3_in[3*k], l3_in[3*k+1], l3_in[3*k+2]);
    assign l3_c[k] = csa_carry(l3_in[3*k], l3_in[3*k+1], l3_in[3*k+2]);
  end

  // level 4: late level-2 carries join level-3 outputs (6 -> 4)
  assign l4_in[0] = l2_c[2];
  assign l4_in[1] = l2_c[3];
  assign l4_in[2] = l3_c[0];
  assign l4_in[3] = l3_c[1];
  assign l4_in[4] = l3_s[0];
  assign l4_in[5] = l3_s[1];

  for (k = 0; k < L4_CSA; k++) begin : g_l4
    assign l4_s[k] = csa_sum(l4_in[3*k], l4_in[3*k+1], l4_in[3*k+2]);
    assign l4_c[k] = csa_carry(l4_in[3*k], l4_in[3*k+1], l4_in[3*k+2]);
  end

  // level 5: 4 -> 3, second level-4 carry passes
  assign l5_s = csa_sum(l4_c[0], l4_s[0], l4_s[1]);
  assign l5_c = csa_carry(l4_c[0], l4_s[0], l4_s[1]);

  // level 6: 3 -> 2
  assign sum_o   = csa_sum(l4_c[1], l5_c, l5_s);
  assign carry_o = csa_carry(l4_c[1], l5_c, l5_s);

endmodule

//--- verilog/booth_encoder.sv
// purely combinational; rows are sign extended to PP_LEN so only the low 64 bits of their sum are valid
`timescale 1ns/1ps

module booth_encoder (
  input  mul_pkg::mul_req_t  req_i,
  output mul_pkg::pp_array_t pp_o
);

  import mul_pkg::*;

  // operands widened by two bits so signed and unsigned share one path
  localparam int EXT_W = DATA_WIDTH + 2;

  logic [EXT_W-1:0]  a_ext;
  // multiplier with the implicit zero below bit 0
  logic [EXT_W:0]    b_ext;
  // per-row negate flag, its +1 lands in the next row
  logic [PP_NUM-1:0] neg;

  assign a_ext = {{2{req_i.mode.a_signed & req_i.multiplicand[DATA_WIDTH-1]}},
                  req_i.multiplicand};
  assign b_ext = {{2{req_i.mode.b_signed & req_i.multiplier[DATA_WIDTH-1]}},
                  req_i.multiplier, 1'b0};

  genvar i;
  for (i = 0; i < PP_NUM; i++) begin : g_row
    logic [2:0]        grp;
    logic              sel_one;
    logic              sel_two;
    logic [EXT_W:0]    mag;
    logic [EXT_W:0]    val;
    logic [PP_LEN-1:0] row;
    logic [PP_LEN-1:0] cin;

    // overlapping 3-bit group b[2i+1], b[2i], b[2i-1]
    assign grp = b_ext[2*i+2 -: 3];

    // 001/010 -> +A, 011 -> +2A, 100 -> -2A, 101/110 -> -A, 000/111 -> 0
    assign sel_one = grp[1] ^ grp[0];
    assign sel_two = (grp[2] & ~grp[1] & ~grp[0]) | (~grp[2] & grp[1] & grp[0]);
    assign neg[i]  = grp[2] & ~(grp[1] & grp[0]);

    assign mag = sel_two ? {a_ext, 1'b0} :
                 sel_one ? {a_ext[EXT_W-1], a_ext} : '0;

    // one's complement here, the +1 is added through cin of the next row
    assign val = mag ^ {(EXT_W + 1){neg[i]}};

    // sign extend to full row width, then weight by 4^i
    assign row = {{(PP_LEN - EXT_W - 1){val[EXT_W]}}, val} << (2 * i);

    if (i == 0) begin : g_first
      assign cin = '0;
    end else begin : g_next
      // bits below 2i are free in this row, bit 2i-2 has the weight of row i-1
      assign cin = PP_LEN'(neg[i-1]) << (2 * i - 2);
    end

    // the top group is always 000, 001 or 111 after extension
    // so neg of the last row never needs a slot
    assign pp_o[i] = row | cin;
  end

endmodule

//--- verilog/mul_pkg.sv
// width is fixed at 32 bits by the 17-row booth array and the six-level tree
package mul_pkg;

  // operand width
  localparam int DATA_WIDTH = 32;

  // radix-4 booth rows, one extra row covers the unsigned top group
  localparam int PP_NUM = DATA_WIDTH / 2 + 1;

  // twice the operand width plus sign and carry guard bits
  localparam int PP_LEN = 2 * DATA_WIDTH + 4;

  // operand signedness
  // mulh sets both, mulhsu sets a only, mulhu clears both
  typedef struct packed {
    logic a_signed;
    logic b_signed;
  } mul_mode_t;

  // one multiply request
  typedef struct packed {
    mul_mode_t             mode;
    logic [DATA_WIDTH-1:0] multiplicand;
    logic [DATA_WIDTH-1:0] multiplier;
  } mul_req_t;

  // full 64-bit product split in two words
  typedef struct packed {
    logic [DATA_WIDTH-1:0] hi;
    logic [DATA_WIDTH-1:0] lo;
  } mul_res_t;

  // one partial product row
  typedef logic [PP_LEN-1:0] pp_row_t;

  // all booth rows, row 0 is the least significant
  typedef pp_row_t [PP_NUM-1:0] pp_array_t;

endpackage
